/* verilog.f */
+incdir+common
common/vst_pkg.sv
vstu/vst_insn_queue.sv
vstu/vst_lane.sv
vstu/vst_addrgen.sv
vstu/vst_beat_packer.sv
source/vst_top.sv
testbench/vst_tb.sv

/* Bender.yml */
package:
  name: vst_store_unit

sources:
  - include_dirs:
      - common
    files:
      - common/vst_pkg.sv
      - vstu/vst_insn_queue.sv
      - vstu/vst_lane.sv
      - vstu/vst_addrgen.sv
      - vstu/vst_beat_packer.sv
      - source/vst_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/vst_tb.sv

/* testbench/vst_tb.sv */
//////////////////////////////////////////////////
// Testbench for the vector store unit
// Register file is loaded once before the first store
// B responses follow the last W beat of each burst
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_tb import vst_pkg::*; ();

  localparam int NumStores  = 40;
  // Worst store is 32 beats in 8 bursts with ready at 3/4
  localparam int CycleLimit = 200 + `VST_NR_LANES * `VST_NR_ROWS + NumStores * 160;

  logic clk_i, rst_ni, vrf_we_i, vrf_wmask_i, req_valid_i, req_ready_o;
  logic [`VST_LANE_W-1:0]  vrf_lane_i;
  logic [`VST_ROW_W-1:0]   vrf_row_i, req_row_i;
  logic [`VST_ELEM_W-1:0]  vrf_wdata_i;
  vst_op_e                 req_op_i;
  logic [`VST_ID_W-1:0]    req_id_i, done_id_o;
  logic [`VST_VL_W-1:0]    req_vl_i;
  logic [`VST_ADDR_W-1:0]  req_addr_i, aw_addr_o;
  logic [7:0]              aw_len_o;
  logic                    aw_valid_o, aw_ready_i, w_valid_o, w_last_o, w_ready_i;
  logic [`VST_BUS_W-1:0]   w_data_o;
  logic [`VST_BUS_W/8-1:0] w_strb_o;
  logic                    b_valid_i, b_ready_o, done_valid_o, store_pending_o;

  // Reference register file and expected traffic
  logic [`VST_ELEM_W-1:0]  model_data [`VST_NR_LANES][`VST_NR_ROWS];
  logic                    model_mask [`VST_NR_LANES][`VST_NR_ROWS];
  logic [`VST_ADDR_W-1:0]  exp_aw_addr [$];
  logic [7:0]              exp_aw_len [$];
  logic [`VST_BUS_W-1:0]   exp_w_data [$];
  logic [`VST_BUS_W/8-1:0] exp_w_strb [$];
  logic                    exp_w_last [$];
  logic [`VST_ID_W-1:0]    exp_ids [$];
  int                      exp_bursts [$];

  // Monitor state updated on the falling edge
  int unsigned             outstanding, accepted, offered, b_credits, head_resps, cycle_cnt;
  logic                    req_taken, done_due, aw_hold, w_hold, hold_w_last;
  logic [`VST_ID_W-1:0]    done_id_exp;
  logic [`VST_ADDR_W-1:0]  hold_aw_addr;
  logic [7:0]              hold_aw_len;
  logic [`VST_BUS_W-1:0]   hold_w_data;
  logic [`VST_BUS_W/8-1:0] hold_w_strb;
  logic [31:0]             lfsr_q;

  vst_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return val;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  // Expected AW and W stream of one accepted store
  task automatic expect_store(input vst_op_e op, input logic [`VST_ROW_W-1:0] row,
                              input logic [`VST_VL_W-1:0] vl,
                              input logic [`VST_ADDR_W-1:0] addr,
                              input logic [`VST_ID_W-1:0] id);
    int beats, bursts, len, e, lane, r;
    logic [`VST_BUS_W-1:0]   data;
    logic [`VST_BUS_W/8-1:0] strb;
    beats  = (int'(vl) + 1) / 2;
    bursts = (beats + `VST_MAX_BURST - 1) / `VST_MAX_BURST;
    for (int k = 0; k < bursts; k++) begin
      len = beats - `VST_MAX_BURST * k;
      len = (len > `VST_MAX_BURST) ? `VST_MAX_BURST : len;
      exp_aw_addr.push_back(addr + 32'(32 * k));
      exp_aw_len.push_back(8'(len - 1));
    end
    for (int j = 0; j < beats; j++) begin
      data = '0;
      strb = '0;
      for (int h = 0; h < 2; h++) begin
        e    = 2 * j + h;
        lane = e % `VST_NR_LANES;
        r    = (int'(row) + e / `VST_NR_LANES) % `VST_NR_ROWS;
        // Tail and masked-off elements stay zero
        if ((e < int'(vl)) && ((op == OP_STORE) || model_mask[lane][r])) begin
          data[32*h +: 32] = model_data[lane][r];
          strb[4*h +: 4]   = 4'hf;
        end
      end
      exp_w_data.push_back(data);
      exp_w_strb.push_back(strb);
      exp_w_last.push_back((j % `VST_MAX_BURST == `VST_MAX_BURST - 1) || (j == beats - 1));
    end
    exp_bursts.push_back(bursts);
    exp_ids.push_back(id);
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] wdata;
    logic        wmask;
    lfsr_q      = 32'h4721f590;
    rst_ni      = 1'b0;
    vrf_we_i    = 1'b0;
    vrf_lane_i  = '0;
    vrf_row_i   = '0;
    vrf_wdata_i = '0;
    vrf_wmask_i = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = OP_STORE;
    req_id_i    = '0;
    req_row_i   = '0;
    req_vl_i    = '0;
    req_addr_i  = '0;
    aw_ready_i  = 1'b0;
    w_ready_i   = 1'b0;
    b_valid_i   = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!aw_valid_o && !w_valid_o && !done_valid_o && !b_ready_o)
      else report_failure($sformatf(
        "mismatch after reset: aw_valid_o %h w_valid_o %h done_valid_o %h b_ready_o %h",
        aw_valid_o, w_valid_o, done_valid_o, b_ready_o));
    assert (!store_pending_o && req_ready_o) else report_failure($sformatf(
      "mismatch after reset: store_pending_o %h req_ready_o %h", store_pending_o, req_ready_o));
    // Load every lane row with random data and mask
    for (int r = 0; r < `VST_NR_ROWS; r++) begin
      for (int l = 0; l < `VST_NR_LANES; l++) begin
        @(posedge clk_i);
        wdata            = take_bits(32);
        wmask            = take_bits(1);
        model_data[l][r] = wdata;
        model_mask[l][r] = wmask;
        vrf_we_i        <= 1'b1;
        vrf_lane_i      <= `VST_LANE_W'(l);
        vrf_row_i       <= `VST_ROW_W'(r);
        vrf_wdata_i     <= wdata;
        vrf_wmask_i     <= wmask;
      end
    end
    @(posedge clk_i);
    vrf_we_i <= 1'b0;
    while ((accepted < NumStores) || (outstanding != 0)) begin
      @(posedge clk_i);
      aw_ready_i <= (take_bits(2) != 0);
      w_ready_i  <= (take_bits(2) != 0);
      b_valid_i  <= (b_credits != 0) && (take_bits(1) != 0);
      if (!req_valid_i || req_taken) begin
        if ((offered < NumStores) && (take_bits(1) != 0)) begin
          req_valid_i <= 1'b1;
          req_op_i    <= vst_op_e'(take_bits(1));
          req_id_i    <= `VST_ID_W'(take_bits(2));
          req_row_i   <= `VST_ROW_W'(take_bits(4));
          req_vl_i    <= `VST_VL_W'(take_bits(6) + 1);
          req_addr_i  <= take_bits(29) << 3;
          offered++;
        end else begin
          req_valid_i <= 1'b0;
        end
      end
    end
    // Let the last done pulse be checked
    repeat (3) @(negedge clk_i);
    if ((exp_aw_addr.size() == 0) && (exp_w_data.size() == 0) && (exp_ids.size() == 0)) begin
      $display("All checks passed");
      $finish;
    end else begin
      report_failure("expected bursts or beats were never sent");
    end
  end

  //////////////////////////////////////////////////
  // Monitor and checks
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // Queue status follows the model's store count
      assert (req_ready_o == (outstanding < `VST_QUEUE_DEPTH)) else report_failure($sformatf(
        "mismatch req_ready_o: got %h, expected %h", req_ready_o,
        outstanding < `VST_QUEUE_DEPTH));
      assert (store_pending_o == (outstanding != 0)) else report_failure($sformatf(
        "mismatch store_pending_o: got %h, expected %h", store_pending_o, outstanding != 0));
      assert (b_ready_o == (outstanding != 0)) else report_failure($sformatf(
        "mismatch b_ready_o: got %h, expected %h", b_ready_o, outstanding != 0));
      assert (done_valid_o == done_due) else report_failure($sformatf(
        "mismatch done_valid_o: got %h, expected %h", done_valid_o, done_due));
      if (done_valid_o) begin
        assert (done_id_o == done_id_exp) else report_failure($sformatf(
          "mismatch done_id_o: got %h, expected %h", done_id_o, done_id_exp));
      end
      done_due = 1'b0;
      // AW held stable under back-pressure
      if (aw_hold) begin
        assert (aw_valid_o && (aw_addr_o == hold_aw_addr) && (aw_len_o == hold_aw_len))
          else report_failure("AW request changed before its handshake");
      end
      if (aw_valid_o && aw_ready_i) begin
        assert (exp_aw_addr.size() != 0) else report_failure("AW handshake with no burst due");
        assert (aw_addr_o == exp_aw_addr[0]) else report_failure($sformatf(
          "mismatch aw_addr_o: got %h, expected %h", aw_addr_o, exp_aw_addr[0]));
        assert (aw_len_o == exp_aw_len[0]) else report_failure($sformatf(
          "mismatch aw_len_o: got %h, expected %h", aw_len_o, exp_aw_len[0]));
        void'(exp_aw_addr.pop_front());
        void'(exp_aw_len.pop_front());
      end
      aw_hold      = aw_valid_o && !aw_ready_i;
      hold_aw_addr = aw_addr_o;
      hold_aw_len  = aw_len_o;
      // W beat held stable under back-pressure
      if (w_hold) begin
        assert (w_valid_o && (w_data_o == hold_w_data) && (w_strb_o == hold_w_strb) &&
                (w_last_o == hold_w_last))
          else report_failure("W beat changed before its handshake");
      end
      if (w_valid_o && w_ready_i) begin
        assert (exp_w_data.size() != 0) else report_failure("W handshake with no beat due");
        assert (w_data_o == exp_w_data[0]) else report_failure($sformatf(
          "mismatch w_data_o: got %h, expected %h", w_data_o, exp_w_data[0]));
        assert (w_strb_o == exp_w_strb[0]) else report_failure($sformatf(
          "mismatch w_strb_o: got %h, expected %h", w_strb_o, exp_w_strb[0]));
        assert (w_last_o == exp_w_last[0]) else report_failure($sformatf(
          "mismatch w_last_o: got %h, expected %h", w_last_o, exp_w_last[0]));
        void'(exp_w_data.pop_front());
        void'(exp_w_strb.pop_front());
        void'(exp_w_last.pop_front());
        if (w_last_o) begin
          b_credits++;
        end
      end
      w_hold      = w_valid_o && !w_ready_i;
      hold_w_data = w_data_o;
      hold_w_strb = w_strb_o;
      hold_w_last = w_last_o;
      // Responses retire the oldest store
      if (b_valid_i && b_ready_o) begin
        b_credits--;
        if (head_resps + 1 == exp_bursts[0]) begin
          done_due    = 1'b1;
          done_id_exp = exp_ids.pop_front();
          void'(exp_bursts.pop_front());
          head_resps  = 0;
          outstanding--;
        end else begin
          head_resps++;
        end
      end
      req_taken = req_valid_i && req_ready_o;
      if (req_taken) begin
        expect_store(req_op_i, req_row_i, req_vl_i, req_addr_i, req_id_i);
        outstanding++;
        accepted++;
      end
    end
  end

  initial begin
    outstanding = 0;
    accepted    = 0;
    offered     = 0;
    b_credits   = 0;
    head_resps  = 0;
    cycle_cnt   = 0;
    req_taken   = 1'b0;
    done_due    = 1'b0;
    aw_hold     = 1'b0;
    w_hold      = 1'b0;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt == CycleLimit) begin
      report_failure("run did not finish within the cycle limit");
    end
  end

endmodule

`default_nettype wire

/* source/vst_top.sv */
//////////////////////////////////////////////////
// Vector store unit, unit-stride 32-bit elements
// Addresses must be 8-byte aligned
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_top import vst_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     vrf_we_i,
  input  logic [`VST_LANE_W-1:0]   vrf_lane_i,
  input  logic [`VST_ROW_W-1:0]    vrf_row_i,
  input  logic [`VST_ELEM_W-1:0]   vrf_wdata_i,
  input  logic                     vrf_wmask_i,
  input  logic                     req_valid_i,
  input  vst_op_e                  req_op_i,
  input  logic [`VST_ID_W-1:0]     req_id_i,
  input  logic [`VST_ROW_W-1:0]    req_row_i,
  input  logic [`VST_VL_W-1:0]     req_vl_i,
  input  logic [`VST_ADDR_W-1:0]   req_addr_i,
  output logic                     req_ready_o,
  output logic                     aw_valid_o,
  output logic [`VST_ADDR_W-1:0]   aw_addr_o,
  output logic [7:0]               aw_len_o,
  input  logic                     aw_ready_i,
  output logic                     w_valid_o,
  output logic [`VST_BUS_W-1:0]    w_data_o,
  output logic [`VST_BUS_W/8-1:0]  w_strb_o,
  output logic                     w_last_o,
  input  logic                     w_ready_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o,
  output logic                     done_valid_o,
  output logic [`VST_ID_W-1:0]     done_id_o,
  output logic                     store_pending_o
);

  // Issue view
  logic                   iss_valid, iss_done;
  vst_op_e                iss_op;
  logic [`VST_VL_W-1:0]   iss_vl;
  logic [`VST_ADDR_W-1:0] iss_addr;

  // Row reads and lane operands
  logic                                      rd_valid;
  logic [`VST_ROW_W-1:0]                     rd_row;
  logic [`VST_NR_LANES-1:0]                  rd_ready;
  logic [`VST_NR_LANES-1:0][`VST_ELEM_W-1:0] op_data;
  logic [`VST_NR_LANES-1:0]                  op_mask, op_valid;
  logic                                      op_ready;

  // Bursts
  logic                    bst_valid, bst_done;
  logic [`VST_BEATS_W-1:0] bst_beats;

  vst_insn_queue i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_id_i        (req_id_i),
    .req_row_i       (req_row_i),
    .req_vl_i        (req_vl_i),
    .req_addr_i      (req_addr_i),
    .req_ready_o     (req_ready_o),
    .iss_valid_o     (iss_valid),
    .iss_op_o        (iss_op),
    .iss_vl_o        (iss_vl),
    .iss_addr_o      (iss_addr),
    .iss_done_i      (iss_done),
    .rd_valid_o      (rd_valid),
    .rd_row_o        (rd_row),
    .rd_ready_i      (rd_ready),
    .b_valid_i       (b_valid_i),
    .b_ready_o       (b_ready_o),
    .done_valid_o    (done_valid_o),
    .done_id_o       (done_id_o),
    .store_pending_o (store_pending_o)
  );

  // Element i sits in lane i mod 4
  for (genvar l = 0; l < `VST_NR_LANES; l++) begin : gen_lanes
    vst_lane #(
      .LaneIdx (l)
    ) i_lane (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .vrf_we_i    (vrf_we_i),
      .vrf_lane_i  (vrf_lane_i),
      .vrf_row_i   (vrf_row_i),
      .vrf_wdata_i (vrf_wdata_i),
      .vrf_wmask_i (vrf_wmask_i),
      .rd_valid_i  (rd_valid),
      .rd_row_i    (rd_row),
      .rd_ready_o  (rd_ready[l]),
      .op_data_o   (op_data[l]),
      .op_mask_o   (op_mask[l]),
      .op_valid_o  (op_valid[l]),
      .op_ready_i  (op_ready)
    );
  end

  vst_addrgen i_addrgen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .iss_valid_i (iss_valid),
    .iss_vl_i    (iss_vl),
    .iss_addr_i  (iss_addr),
    .aw_valid_o  (aw_valid_o),
    .aw_addr_o   (aw_addr_o),
    .aw_len_o    (aw_len_o),
    .aw_ready_i  (aw_ready_i),
    .bst_valid_o (bst_valid),
    .bst_beats_o (bst_beats),
    .bst_done_i  (bst_done)
  );

  vst_beat_packer i_beat_packer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .iss_valid_i (iss_valid),
    .iss_op_i    (iss_op),
    .iss_vl_i    (iss_vl),
    .iss_done_o  (iss_done),
    .op_data_i   (op_data),
    .op_mask_i   (op_mask),
    .op_valid_i  (op_valid),
    .op_ready_o  (op_ready),
    .bst_valid_i (bst_valid),
    .bst_beats_i (bst_beats),
    .bst_done_o  (bst_done),
    .w_valid_o   (w_valid_o),
    .w_data_o    (w_data_o),
    .w_strb_o    (w_strb_o),
    .w_last_o    (w_last_o),
    .w_ready_i   (w_ready_i)
  );

endmodule

`default_nettype wire

/* vstu/vst_beat_packer.sv */
//////////////////////////////////////////////////
// Packs two 32-bit lane words into each 64-bit beat
// No register on the data path, W follows the operands
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_beat_packer import vst_pkg::*; (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       iss_valid_i,
  input  vst_op_e                                    iss_op_i,
  input  logic [`VST_VL_W-1:0]                       iss_vl_i,
  output logic                                       iss_done_o,
  input  logic [`VST_NR_LANES-1:0][`VST_ELEM_W-1:0]  op_data_i,
  input  logic [`VST_NR_LANES-1:0]                   op_mask_i,
  input  logic [`VST_NR_LANES-1:0]                   op_valid_i,
  output logic                                       op_ready_o,
  input  logic                                       bst_valid_i,
  input  logic [`VST_BEATS_W-1:0]                    bst_beats_i,
  output logic                                       bst_done_o,
  output logic                                       w_valid_o,
  output logic [`VST_BUS_W-1:0]                      w_data_o,
  output logic [`VST_BUS_W/8-1:0]                    w_strb_o,
  output logic                                       w_last_o,
  input  logic                                       w_ready_i
);

  localparam int unsigned ElemsPerBeat = `VST_BUS_W / `VST_ELEM_W;
  localparam int unsigned ElemBytes    = `VST_ELEM_W / 8;

  // Beat counters and the half-word select
  logic [`VST_VL_W-1:0]    st_beat_q, st_beats;
  logic [`VST_BEATS_W-1:0] bst_beat_q;
  logic                    half_q;
  logic                    fire, bst_last, st_last;

  assign st_beats  = (iss_vl_i + `VST_VL_W'(1)) >> 1;
  assign w_valid_o = iss_valid_i && (&op_valid_i) && bst_valid_i;
  assign fire      = w_valid_o && w_ready_i;
  assign bst_last  = (bst_beat_q == bst_beats_i - `VST_BEATS_W'(1));
  assign st_last   = (st_beat_q == st_beats - `VST_VL_W'(1));
  assign w_last_o  = bst_last;

  // Pop the row after its upper half or at the end of the store
  assign op_ready_o = fire && (half_q || st_last);
  assign bst_done_o = fire && bst_last;
  assign iss_done_o = fire && st_last;

  //////////////////////////////////////////////////
  // Data and strobes
  //////////////////////////////////////////////////

  always_comb begin : p_pack
    logic [`VST_LANE_W-1:0] lane;
    logic [`VST_VL_W-1:0]   elem;
    w_data_o = '0;
    w_strb_o = '0;
    for (int h = 0; h < ElemsPerBeat; h++) begin
      lane = `VST_LANE_W'(ElemsPerBeat * half_q + h);
      elem = `VST_VL_W'(ElemsPerBeat * st_beat_q + h);
      // Tail elements and masked-off elements stay zero
      if ((elem < iss_vl_i) && ((iss_op_i == OP_STORE) || op_mask_i[lane])) begin
        w_data_o[h*`VST_ELEM_W +: `VST_ELEM_W] = op_data_i[lane];
        w_strb_o[h*ElemBytes +: ElemBytes]     = '1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_beat_q  <= '0;
      bst_beat_q <= '0;
      half_q     <= 1'b0;
    end else if (fire) begin
      if (st_last) begin
        st_beat_q <= '0;
        half_q    <= 1'b0;
      end else begin
        st_beat_q <= st_beat_q + `VST_VL_W'(1);
        half_q    <= ~half_q;
      end
      if (bst_last) begin
        bst_beat_q <= '0;
      end else begin
        bst_beat_q <= bst_beat_q + `VST_BEATS_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* vstu/vst_addrgen.sv */
//////////////////////////////////////////////////
// AW bursts of up to four beats, no 4 KB split
// A burst reaches the packer only after its AW handshake
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_addrgen import vst_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     iss_valid_i,
  input  logic [`VST_VL_W-1:0]     iss_vl_i,
  input  logic [`VST_ADDR_W-1:0]   iss_addr_i,
  output logic                     aw_valid_o,
  output logic [`VST_ADDR_W-1:0]   aw_addr_o,
  output logic [7:0]               aw_len_o,
  input  logic                     aw_ready_i,
  output logic                     bst_valid_o,
  output logic [`VST_BEATS_W-1:0]  bst_beats_o,
  input  logic                     bst_done_i
);

  localparam int unsigned BurstBytes = `VST_MAX_BURST * `VST_BUS_W / 8;

  vst_ag_state_e          state_q;
  // Beats still without an AW, and beats not yet written
  logic [`VST_VL_W-1:0]   aw_left_q, bst_left_q, iss_beats;
  logic [`VST_ADDR_W-1:0] aw_addr_q;
  logic [`VST_BEATS_W-1:0] aw_beats;

  assign iss_beats = (iss_vl_i + `VST_VL_W'(1)) >> 1;

  // Only the last burst may be short
  assign aw_beats    = (aw_left_q < `VST_VL_W'(`VST_MAX_BURST)) ?
                       `VST_BEATS_W'(aw_left_q) : `VST_BEATS_W'(`VST_MAX_BURST);
  assign bst_beats_o = (bst_left_q < `VST_VL_W'(`VST_MAX_BURST)) ?
                       `VST_BEATS_W'(bst_left_q) : `VST_BEATS_W'(`VST_MAX_BURST);

  assign aw_valid_o  = (state_q == AG_BURST);
  assign aw_addr_o   = aw_addr_q;
  assign aw_len_o    = 8'(aw_beats) - 8'd1;
  // Some burst has its AW out but is not written yet
  assign bst_valid_o = (state_q != AG_IDLE) && (bst_left_q > aw_left_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= AG_IDLE;
      aw_left_q  <= '0;
      bst_left_q <= '0;
      aw_addr_q  <= '0;
    end else begin
      case (state_q)
        AG_IDLE: begin
          if (iss_valid_i) begin
            aw_left_q  <= iss_beats;
            bst_left_q <= iss_beats;
            aw_addr_q  <= iss_addr_i;
            state_q    <= AG_BURST;
          end
        end
        AG_BURST: begin
          if (aw_ready_i) begin
            aw_left_q <= aw_left_q - `VST_VL_W'(aw_beats);
            aw_addr_q <= aw_addr_q + `VST_ADDR_W'(BurstBytes);
            if (aw_left_q == `VST_VL_W'(aw_beats)) begin
              state_q <= AG_WAIT;
            end
          end
        end
        AG_WAIT: begin
          // Store drained once the final burst is written
          if (bst_done_i && (bst_left_q == `VST_VL_W'(bst_beats_o))) begin
            state_q <= AG_IDLE;
          end
        end
        default: state_q <= AG_IDLE;
      endcase
      if (bst_valid_o && bst_done_i) begin
        bst_left_q <= bst_left_q - `VST_VL_W'(bst_beats_o);
      end
    end
  end

endmodule

`default_nettype wire

/* vstu/vst_lane.sv */
//////////////////////////////////////////////////
// One lane slice with a two-entry operand buffer
// A read and a write to the same row see the old word
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_lane #(
  parameter int unsigned LaneIdx = 0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    vrf_we_i,
  input  logic [`VST_LANE_W-1:0]  vrf_lane_i,
  input  logic [`VST_ROW_W-1:0]   vrf_row_i,
  input  logic [`VST_ELEM_W-1:0]  vrf_wdata_i,
  input  logic                    vrf_wmask_i,
  input  logic                    rd_valid_i,
  input  logic [`VST_ROW_W-1:0]   rd_row_i,
  output logic                    rd_ready_o,
  output logic [`VST_ELEM_W-1:0]  op_data_o,
  output logic                    op_mask_o,
  output logic                    op_valid_o,
  input  logic                    op_ready_i
);

  localparam int unsigned BufDepth = 2;

  // Register slice, one element and its mask bit per row
  logic [`VST_ELEM_W-1:0] data_mem [`VST_NR_ROWS];
  logic                   mask_mem [`VST_NR_ROWS];

  logic [`VST_ELEM_W-1:0] buf_data_q [BufDepth];
  logic                   buf_mask_q [BufDepth];
  logic                   wr_pnt_q, rd_pnt_q;
  logic [1:0]             cnt_q;
  logic                   push, pop;

  assign rd_ready_o = (cnt_q != 2'(BufDepth));
  assign op_valid_o = (cnt_q != '0);
  assign op_data_o  = buf_data_q[rd_pnt_q];
  assign op_mask_o  = buf_mask_q[rd_pnt_q];
  assign push       = rd_valid_i && rd_ready_o;
  assign pop        = op_valid_o && op_ready_i;

  always_ff @(posedge clk_i) begin
    if (vrf_we_i && (vrf_lane_i == `VST_LANE_W'(LaneIdx))) begin
      data_mem[vrf_row_i] <= vrf_wdata_i;
      mask_mem[vrf_row_i] <= vrf_wmask_i;
    end
    // Row lands in the buffer at the read edge
    if (push) begin
      buf_data_q[wr_pnt_q] <= data_mem[rd_row_i];
      buf_mask_q[wr_pnt_q] <= mask_mem[rd_row_i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= 1'b0;
      rd_pnt_q <= 1'b0;
      cnt_q    <= '0;
    end else begin
      wr_pnt_q <= wr_pnt_q ^ push;
      rd_pnt_q <= rd_pnt_q ^ pop;
      cnt_q    <= cnt_q + 2'(push) - 2'(pop);
    end
  end

endmodule

`default_nettype wire

/* vstu/vst_insn_queue.sv */
//////////////////////////////////////////////////
// Store queue of four entries, retired in order
// B error codes are not looked at
// Row reads restart only once the issuing store is done
//////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none
`include "vst_defines.svh"

module vst_insn_queue import vst_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_valid_i,
  input  vst_op_e                  req_op_i,
  input  logic [`VST_ID_W-1:0]     req_id_i,
  input  logic [`VST_ROW_W-1:0]    req_row_i,
  input  logic [`VST_VL_W-1:0]     req_vl_i,
  input  logic [`VST_ADDR_W-1:0]   req_addr_i,
  output logic                     req_ready_o,
  output logic                     iss_valid_o,
  output vst_op_e                  iss_op_o,
  output logic [`VST_VL_W-1:0]     iss_vl_o,
  output logic [`VST_ADDR_W-1:0]   iss_addr_o,
  input  logic                     iss_done_i,
  output logic                     rd_valid_o,
  output logic [`VST_ROW_W-1:0]    rd_row_o,
  input  logic [`VST_NR_LANES-1:0] rd_ready_i,
  input  logic                     b_valid_i,
  output logic                     b_ready_o,
  output logic                     done_valid_o,
  output logic [`VST_ID_W-1:0]     done_id_o,
  output logic                     store_pending_o
);

  localparam int unsigned PntW = $clog2(`VST_QUEUE_DEPTH);
  localparam int unsigned CntW = PntW + 1;

  // Entry payload
  vst_op_e                op_q     [`VST_QUEUE_DEPTH];
  logic [`VST_ID_W-1:0]   id_q     [`VST_QUEUE_DEPTH];
  logic [`VST_ROW_W-1:0]  row_q    [`VST_QUEUE_DEPTH];
  logic [`VST_VL_W-1:0]   vl_q     [`VST_QUEUE_DEPTH];
  logic [`VST_ADDR_W-1:0] addr_q   [`VST_QUEUE_DEPTH];
  logic [`VST_VL_W-1:0]   bursts_q [`VST_QUEUE_DEPTH];

  // Pointers for the accept, issue and commit phases
  logic [PntW-1:0]      accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [CntW-1:0]      issue_cnt_q, commit_cnt_q;
  logic [`VST_VL_W-1:0] rd_cnt_q, resp_cnt_q;
  logic [`VST_VL_W-1:0] req_beats, req_bursts, iss_rows;
  logic                 accept, issue_adv, rd_fire, b_fire, retire, done_valid_q;
  logic [`VST_ID_W-1:0] done_id_q;

  assign req_ready_o     = (commit_cnt_q != CntW'(`VST_QUEUE_DEPTH));
  assign store_pending_o = (commit_cnt_q != '0);
  assign accept          = req_valid_i && req_ready_o;

  // Two elements per beat, then bursts of MAX_BURST beats
  assign req_beats  = (req_vl_i + `VST_VL_W'(1)) >> 1;
  assign req_bursts = (req_beats + `VST_VL_W'(`VST_MAX_BURST - 1)) >> $clog2(`VST_MAX_BURST);

  //////////////////////////////////////////////////
  // Issue view and row reads
  //////////////////////////////////////////////////

  assign iss_valid_o = (issue_cnt_q != '0);
  assign iss_op_o    = op_q[issue_pnt_q];
  assign iss_vl_o    = vl_q[issue_pnt_q];
  assign iss_addr_o  = addr_q[issue_pnt_q];
  assign issue_adv   = iss_valid_o && iss_done_i;

  // One row holds one element per lane
  assign iss_rows   = (vl_q[issue_pnt_q] + `VST_VL_W'(`VST_NR_LANES - 1)) >>
                      $clog2(`VST_NR_LANES);
  assign rd_valid_o = iss_valid_o && (rd_cnt_q < iss_rows);
  assign rd_row_o   = row_q[issue_pnt_q] + `VST_ROW_W'(rd_cnt_q);
  assign rd_fire    = rd_valid_o && (&rd_ready_i);

  //////////////////////////////////////////////////
  // Responses
  //////////////////////////////////////////////////

  // Every store in the queue may still see responses
  assign b_ready_o    = store_pending_o;
  assign b_fire       = b_valid_i && b_ready_o;
  assign retire       = b_fire && (resp_cnt_q + `VST_VL_W'(1) == bursts_q[commit_pnt_q]);
  assign done_valid_o = done_valid_q;
  assign done_id_o    = done_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      rd_cnt_q     <= '0;
      resp_cnt_q   <= '0;
      done_valid_q <= 1'b0;
    end else begin
      accept_pnt_q <= accept_pnt_q + PntW'(accept);
      issue_pnt_q  <= issue_pnt_q + PntW'(issue_adv);
      commit_pnt_q <= commit_pnt_q + PntW'(retire);
      issue_cnt_q  <= issue_cnt_q + CntW'(accept) - CntW'(issue_adv);
      commit_cnt_q <= commit_cnt_q + CntW'(accept) - CntW'(retire);
      // Row counter restarts for the next issuing store
      if (issue_adv) begin
        rd_cnt_q <= '0;
      end else if (rd_fire) begin
        rd_cnt_q <= rd_cnt_q + `VST_VL_W'(1);
      end
      if (retire) begin
        resp_cnt_q <= '0;
      end else if (b_fire) begin
        resp_cnt_q <= resp_cnt_q + `VST_VL_W'(1);
      end
      done_valid_q <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]     <= req_op_i;
      id_q[accept_pnt_q]     <= req_id_i;
      row_q[accept_pnt_q]    <= req_row_i;
      vl_q[accept_pnt_q]     <= req_vl_i;
      addr_q[accept_pnt_q]   <= req_addr_i;
      bursts_q[accept_pnt_q] <= req_bursts;
    end
    if (retire) begin
      done_id_q <= id_q[commit_pnt_q];
    end
  end

endmodule

`default_nettype wire

/* common/vst_pkg.sv */
//////////////////////////////////////////////////
// Types shared by the vector store unit
//////////////////////////////////////////////////

`default_nettype none

package vst_pkg;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // Plain store writes all elements below vl
  typedef enum logic {
    OP_STORE        = 1'b0,
    OP_STORE_MASKED = 1'b1
  } vst_op_e;

  //////////////////////////////////////////////////
  // Address generator
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    AG_IDLE  = 2'd0,
    AG_BURST = 2'd1,
    AG_WAIT  = 2'd2
  } vst_ag_state_e;

endpackage

`default_nettype wire

/* common/vst_defines.svh */
//////////////////////////////////////////////////
// Sizing of the vector store unit
// Lane count and beat width are tied to 32-bit elements
//////////////////////////////////////////////////

`ifndef VST_DEFINES_SVH
`define VST_DEFINES_SVH

// Lanes and register slices
`define VST_NR_LANES    4
`define VST_LANE_W      2
`define VST_NR_ROWS     16
`define VST_ROW_W       4
`define VST_ELEM_W      32

// Store queue and bus
`define VST_QUEUE_DEPTH 4
`define VST_MAX_BURST   4
`define VST_BEATS_W     3
`define VST_BUS_W       64
`define VST_ADDR_W      32
`define VST_ID_W        2
`define VST_VL_W        7

`endif
